// ==== compile.f ====
hw/grn_pkg.sv
hw/grn_csr.sv
hw/grn_network.sv
hw/transient_fifo.sv
hw/grn_requestor.sv
hw/grn_afu.sv
testbench/grn_checker.sv
testbench/tb_grn_afu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the GRN unit testbench with Verilator and runs it.
# Exits 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_grn_afu -Mdir obj_dir -o sim_grn
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/sim_grn)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "TEST OK"; then
  exit 0
fi
echo "Pass line not found in the simulation output"
exit 1

// ==== testbench/tb_grn_afu.sv ====
/*
 * Top testbench of the GRN unit.
 * Builds a table of runs, drives each through the AXI4-Lite port (seed,
 * steps, start, status polling, memory readback, unmapped read) and leaves
 * all comparing to grn_checker. A cycle watchdog bounds the run.
 */
`timescale 1ns/100ps

module tb_grn_afu;

  localparam int num_rows        = 8;
  localparam int per_read_cycles = 8;
  localparam int row_cycles      = 100;
  localparam int extra_cycles    = 200;

  logic        clk;
  logic        rst_n;
  logic [11:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [11:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        test_end;
  int          test_id;
  int          error_count;
  int          check_count;

  // Stimulus table with one run per row
  logic [15:0] row_seed [num_rows];
  int          row_steps [num_rows];
  bit          row_legal [num_rows];
  bit          row_restart [num_rows];

  int cycle_count = 0;
  int timeout_limit;

  grn_afu dut (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  grn_checker u_checker (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .test_end(test_end), .test_id(test_id),
    .error_count(error_count), .check_count(check_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Load one row of the stimulus table
  function automatic void set_row(input int r, input logic [15:0] s, input int n,
                                  input bit legal, input bit restart);
    row_seed[r]    = s;
    row_steps[r]   = n;
    row_legal[r]   = legal;
    row_restart[r] = restart;
  endfunction

  // Corner rows come first and random rows fill the rest
  // Each illegal count follows a legal one that it must leave in place
  // Restart rows need a run long enough to still be busy at the second start
  task automatic fill_table();
    int effective;
    void'($urandom(55490));
    set_row(0, 16'hACE1, 1, 1'b1, 1'b0);
    set_row(1, 16'hBEEF, 65, 1'b0, 1'b0);
    set_row(2, 16'h1D2C, 64, 1'b1, 1'b1);
    set_row(3, 16'h0F0F, 0, 1'b0, 1'b0);
    for (int r = 4; r < num_rows; r++) begin
      row_seed[r]    = 16'($urandom);
      row_restart[r] = (r % 2) == 1;
      row_legal[r]   = 1'b1;
      if (row_restart[r]) begin
        row_steps[r] = 8 + int'($urandom % 57);
      end else begin
        row_steps[r] = 1 + int'($urandom % 64);
      end
    end
    // Illegal rows rerun the previous count, so budget them at the maximum
    timeout_limit = extra_cycles;
    for (int r = 0; r < num_rows; r++) begin
      effective = row_legal[r] ? row_steps[r] : grn_pkg::max_steps;
      timeout_limit += effective * per_read_cycles + row_cycles;
    end
  endtask

  // Handshakes are judged at the falling edge, where nothing is changing
  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // Poll status until the done bit shows up
  task automatic wait_done();
    logic [31:0] status;
    status = '0;
    while (!status[1]) begin
      read_reg(grn_pkg::reg_status, status);
    end
  endtask

  task automatic end_test();
    @(posedge clk);
    #1;
    test_end = 1'b1;
    @(posedge clk);
    #1;
    test_end = 1'b0;
  endtask

  initial begin
    logic [31:0] rd_word;
    int          eff_steps;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    rst_n    = 1'b0;
    test_end = 1'b0;
    test_id  = 0;
    fill_table();
    repeat (4) @(posedge clk);
    #1;
    rst_n     = 1'b1;
    eff_steps = 1;
    for (int r = 0; r < num_rows; r++) begin
      test_id = r;
      write_reg(grn_pkg::reg_seed, {16'h0, row_seed[r]});
      write_reg(grn_pkg::reg_steps, 32'(row_steps[r]));
      // Read back to show whether the step count was taken
      read_reg(grn_pkg::reg_steps, rd_word);
      if (row_legal[r]) begin
        eff_steps = row_steps[r];
      end
      write_reg(grn_pkg::reg_ctrl, 32'h1);
      // A second start with a new seed lands while the network is busy
      if (row_restart[r]) begin
        write_reg(grn_pkg::reg_seed, {16'h0, ~row_seed[r]});
        write_reg(grn_pkg::reg_ctrl, 32'h1);
      end
      wait_done();
      for (int k = 0; k < eff_steps; k++) begin
        read_reg(grn_pkg::mem_base + 12'(4 * k), rd_word);
      end
      read_reg(12'h200 + 12'(4 * r), rd_word);
      end_test();
    end
    repeat (2) @(posedge clk);
    $display("Tests %0d, checks %0d, errors %0d", num_rows, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/grn_checker.sv ====
/*
 * Scoreboard for the GRN unit testbench.
 * Snoops the AXI4-Lite handshakes, keeps its own copy of the seed and step
 * registers, models the gene network and compares every bresp, rresp and
 * rdata and the response latencies. Prints one line per test and exports
 * its check and error counts.
 */
`timescale 1ns/100ps

module grn_checker (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [grn_pkg::addr_width-1:0]     awaddr,
  input  logic                               awvalid,
  input  logic                               awready,
  input  logic [grn_pkg::data_width-1:0]     wdata,
  input  logic                               wvalid,
  input  logic                               wready,
  input  logic [1:0]                         bresp,
  input  logic                               bvalid,
  input  logic                               bready,
  input  logic [grn_pkg::addr_width-1:0]     araddr,
  input  logic                               arvalid,
  input  logic                               arready,
  input  logic [grn_pkg::data_width-1:0]     rdata,
  input  logic [1:0]                         rresp,
  input  logic                               rvalid,
  input  logic                               rready,
  input  logic                               test_end,
  input  int                                 test_id,
  output int                                 error_count,
  output int                                 check_count
);

  // How a read response is judged
  localparam int kind_exact     = 0;
  localparam int kind_status    = 1;
  localparam int kind_resp_only = 2;

  // A start is ignored until the running job has drained and a few slack cycles pass
  localparam int run_slack = 4;

  logic [15:0] seed_model;
  int          steps_model;
  logic [15:0] run_seed;
  int          run_steps;
  int          run_age;
  logic [15:0] model_state [grn_pkg::max_steps];
  logic        wr_pending;
  logic [1:0]  exp_bresp;
  int          wr_latency;
  logic        rd_pending;
  logic [1:0]  exp_rresp;
  logic [31:0] exp_rdata;
  int          rd_kind;
  logic [11:0] rd_addr;
  int          rd_latency;
  int          exp_rd_latency;
  int          errors_at_start;

  // Gene i gets gene i+1 xor (gene i+3 and not gene i+5) through rotations
  function automatic logic [15:0] step_genes(input logic [15:0] s);
    logic [15:0] r1;
    logic [15:0] r3;
    logic [15:0] r5;
    r1 = {s[0], s[15:1]};
    r3 = {s[2:0], s[15:3]};
    r5 = {s[4:0], s[15:5]};
    return r1 ^ (r3 & ~r5);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("Checker: %s", what);
  endtask

  // Latch the run parameters and build the whole trajectory
  task automatic start_run();
    run_seed       = seed_model;
    run_steps      = steps_model;
    run_age        = 0;
    model_state[0] = seed_model;
    for (int k = 1; k < grn_pkg::max_steps; k++) begin
      model_state[k] = step_genes(model_state[k-1]);
    end
  endtask

  task automatic snoop_write();
    exp_bresp = grn_pkg::resp_okay;
    case (awaddr)
      grn_pkg::reg_ctrl: begin
        if (wdata[0] && run_age >= run_steps + run_slack) begin
          start_run();
        end
      end
      grn_pkg::reg_seed: seed_model = wdata[15:0];
      grn_pkg::reg_steps: begin
        // Legal step counts are 1 to 64, anything else keeps the old value
        if (wdata >= 32'd1 && wdata <= 32'(grn_pkg::max_steps)) begin
          steps_model = int'(wdata);
        end else begin
          exp_bresp = grn_pkg::resp_slverr;
        end
      end
      default: exp_bresp = grn_pkg::resp_slverr;
    endcase
    wr_pending = 1'b1;
    wr_latency = 0;
  endtask

  task automatic snoop_read();
    rd_addr        = araddr;
    exp_rresp      = grn_pkg::resp_okay;
    exp_rdata      = '0;
    rd_kind        = kind_exact;
    exp_rd_latency = 1;
    case (araddr)
      grn_pkg::reg_ctrl:   exp_rdata = '0;
      grn_pkg::reg_seed:   exp_rdata = {16'h0, seed_model};
      grn_pkg::reg_steps:  exp_rdata = 32'(steps_model);
      grn_pkg::reg_status: rd_kind = kind_status;
      default: begin
        if (araddr[11:8] == grn_pkg::mem_base[11:8]) begin
          // Memory reads pass through one wait cycle
          exp_rd_latency = 2;
          // The record holds 10 zero bits, a 6-bit step and a 16-bit state
          if (int'(araddr[7:2]) < run_steps) begin
            exp_rdata = {10'b0, araddr[7:2], model_state[araddr[7:2]]};
          end else begin
            rd_kind = kind_resp_only;
          end
        end else begin
          exp_rresp = grn_pkg::resp_slverr;
        end
      end
    endcase
    rd_pending = 1'b1;
    rd_latency = 0;
  endtask

  // Busy in bit 0, done in bit 1, count in bits 14:8
  task automatic check_status();
    check_value("status reserved bits", 32'h0, rdata & ~32'h0000_7F03);
    if (rdata[1]) begin
      check_value("status busy", 32'h0, {31'b0, rdata[0]});
      check_value("status count", 32'(run_steps), {25'b0, rdata[14:8]});
    end else if (int'(rdata[14:8]) > run_steps) begin
      report_failure("status count is beyond the run length while done is clear");
    end
  endtask

  // Bus signals are sampled mid-cycle where they are settled
  always @(negedge clk) begin
    if (!rst_n) begin
      seed_model      = '0;
      steps_model     = 1;
      run_seed        = '0;
      run_steps       = 0;
      run_age         = 1000;
      wr_pending      = 1'b0;
      wr_latency      = 0;
      rd_pending      = 1'b0;
      rd_latency      = 0;
      exp_rd_latency  = 1;
      error_count     = 0;
      check_count     = 0;
      errors_at_start = 0;
    end else begin
      run_age++;
      // Cycles since the handshake of the outstanding access
      if (wr_pending) begin
        wr_latency++;
      end
      if (rd_pending) begin
        rd_latency++;
      end
      if (awvalid && awready && wvalid && wready) begin
        snoop_write();
      end
      if (bvalid && bready) begin
        if (wr_pending) begin
          check_value($sformatf("bresp at 0x%h", awaddr), 32'(exp_bresp), 32'(bresp));
          check_value("bvalid latency", 32'd1, 32'(wr_latency));
        end else begin
          report_failure("a write response arrived with no write outstanding");
        end
        wr_pending = 1'b0;
      end
      if (arvalid && arready) begin
        snoop_read();
      end
      if (rvalid && rready) begin
        if (!rd_pending) begin
          report_failure("read data arrived with no read outstanding");
        end else begin
          check_value($sformatf("rresp at 0x%h", rd_addr), 32'(exp_rresp), 32'(rresp));
          check_value($sformatf("rvalid latency at 0x%h", rd_addr),
                      32'(exp_rd_latency), 32'(rd_latency));
          if (rd_kind == kind_exact) begin
            check_value($sformatf("rdata at 0x%h", rd_addr), exp_rdata, rdata);
          end else if (rd_kind == kind_status) begin
            check_status();
          end
        end
        rd_pending = 1'b0;
      end
      if (test_end) begin
        $display("Test %0d seed 0x%h steps %0d: %0d errors, %s", test_id, run_seed,
                 run_steps, error_count - errors_at_start,
                 (error_count == errors_at_start) ? "passed" : "failed");
        errors_at_start = error_count;
      end
    end
  end

endmodule

// ==== hw/grn_afu.sv ====
/*
 * Top level of the GRN accelerator function unit.
 * The host programs and starts runs through the AXI4-Lite port, then reads
 * the result memory back through the same port. Only wiring lives here.
 */
`timescale 1ns/100ps

module grn_afu (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [grn_pkg::addr_width-1:0]     awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [grn_pkg::data_width-1:0]     wdata,
  input  logic [grn_pkg::data_width/8-1:0]   wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  logic                               bready,
  input  logic [grn_pkg::addr_width-1:0]     araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [grn_pkg::data_width-1:0]     rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  logic                               rready
);

  // Run control between the CSR block and the datapath
  logic                             start;
  logic [grn_pkg::gene_count-1:0]   seed;
  logic [grn_pkg::step_width:0]     steps;
  logic                             busy;
  logic                             done;
  logic [grn_pkg::step_width:0]     count;
  logic [grn_pkg::step_width-1:0]   mem_rd_addr;
  logic [grn_pkg::data_width-1:0]   mem_rd_data;

  // Producer side of the FIFO
  logic                             push;
  grn_pkg::transient_t              push_record;
  logic                             push_last;
  logic                             full;

  // Consumer side of the FIFO
  logic                             pop;
  logic                             pop_valid;
  grn_pkg::transient_t              pop_record;
  logic                             pop_last;

  grn_csr u_grn_csr (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .start(start), .seed(seed), .steps(steps), .busy(busy), .done(done),
    .count(count), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data)
  );

  grn_network u_grn_network (
    .clk(clk), .rst_n(rst_n), .start(start), .seed(seed), .steps(steps),
    .full(full), .push(push), .push_record(push_record),
    .push_last(push_last), .busy(busy)
  );

  transient_fifo u_transient_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(push), .push_record(push_record), .push_last(push_last), .full(full),
    .pop(pop), .pop_valid(pop_valid), .pop_record(pop_record), .pop_last(pop_last)
  );

  grn_requestor u_grn_requestor (
    .clk(clk), .rst_n(rst_n), .start(start),
    .pop_valid(pop_valid), .pop_record(pop_record), .pop_last(pop_last), .pop(pop),
    .done(done), .count(count), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data)
  );

endmodule

// ==== hw/grn_requestor.sv ====
/*
 * Consumer side of the record FIFO.
 * Stores every record in the result memory at its step index, counts the
 * records of the current run and raises done on the last one. The CSR block
 * reads the memory through a registered port with one cycle of latency.
 */
`timescale 1ns/100ps

module grn_requestor (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  logic                             pop_valid,
  input  grn_pkg::transient_t              pop_record,
  input  logic                             pop_last,
  output logic                             pop,
  output logic                             done,
  output logic [grn_pkg::step_width:0]     count,
  input  logic [grn_pkg::step_width-1:0]   mem_rd_addr,
  output logic [grn_pkg::data_width-1:0]   mem_rd_data
);

  // Result memory, one raw record word per step
  logic [grn_pkg::data_width-1:0] result_mem [grn_pkg::max_steps];

  // One write per cycle keeps up with any producer rate
  assign pop = pop_valid;

  // Run bookkeeping
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done  <= 1'b0;
      count <= '0;
    end else if (start) begin
      // A new run starts from an empty count
      done  <= 1'b0;
      count <= '0;
    end else if (pop) begin
      count <= count + 1'b1;
      if (pop_last) begin
        done <= 1'b1;
      end
    end
  end

  // The step field of a record picks its word
  always_ff @(posedge clk) begin
    if (pop) begin
      result_mem[pop_record.fields.step] <= pop_record.raw;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    mem_rd_data <= result_mem[mem_rd_addr];
  end

endmodule

// ==== hw/transient_fifo.sv ====
/*
 * Synchronous FIFO carrying transient records and their last flag.
 * Sits between the network and the requestor, and is the only buffer
 * between them. Pop takes effect in the same cycle that it is high.
 */
`timescale 1ns/100ps

module transient_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push,
  input  grn_pkg::transient_t  push_record,
  input  logic                 push_last,
  output logic                 full,
  input  logic                 pop,
  output logic                 pop_valid,
  output grn_pkg::transient_t  pop_record,
  output logic                 pop_last
);

  logic [grn_pkg::fifo_ptr_width-1:0]  wr_ptr;
  logic [grn_pkg::fifo_ptr_width-1:0]  rd_ptr;
  logic [grn_pkg::fifo_ptr_width:0]    fill;
  grn_pkg::transient_t                 rec_mem [grn_pkg::fifo_depth];
  logic                                last_mem [grn_pkg::fifo_depth];

  assign full       = fill == (grn_pkg::fifo_ptr_width+1)'(grn_pkg::fifo_depth);
  assign pop_valid  = fill != '0;
  assign pop_record = rec_mem[rd_ptr];
  assign pop_last   = last_mem[rd_ptr];

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      rec_mem[wr_ptr]  <= push_record;
      last_mem[wr_ptr] <= push_last;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("push into a full FIFO");

  assert property (@(posedge clk) disable iff (!rst_n) pop |-> pop_valid)
    else $error("pop from an empty FIFO");

endmodule

// ==== hw/grn_network.sv ====
/*
 * Boolean network stepper for 16 genes.
 * A start pulse loads the seed, and each accepted push advances the state by
 * one step of the update rule. One record is offered per step; the record
 * and the state hold while the FIFO is full.
 */
`timescale 1ns/100ps

module grn_network (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  logic [grn_pkg::gene_count-1:0]   seed,
  input  logic [grn_pkg::step_width:0]     steps,
  input  logic                             full,
  output logic                             push,
  output grn_pkg::transient_t              push_record,
  output logic                             push_last,
  output logic                             busy
);

  logic [grn_pkg::gene_count-1:0]  state_q;
  logic [grn_pkg::gene_count-1:0]  state_next;
  logic [grn_pkg::step_width-1:0]  step_q;
  logic [grn_pkg::step_width-1:0]  last_step;
  logic [grn_pkg::step_width:0]    steps_m1;

  // Gene i takes gene i+1 xor (gene i+3 and not gene i+5), indices wrap
  always_comb begin
    for (int i = 0; i < grn_pkg::gene_count; i++) begin
      state_next[i] = state_q[(i+1) % grn_pkg::gene_count] ^
                      (state_q[(i+3) % grn_pkg::gene_count] &
                       ~state_q[(i+5) % grn_pkg::gene_count]);
    end
  end

  // Steps is 1 to 64, so the final index always fits the step field
  assign steps_m1 = steps - 1'b1;

  assign push      = busy && !full;
  assign push_last = step_q == last_step;

  // Records are built field by field
  always_comb begin
    push_record.fields.spare = '0;
    push_record.fields.step  = step_q;
    push_record.fields.state = state_q;
  end

  // Run control and step counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      step_q    <= '0;
      last_step <= '0;
    end else if (start && !busy) begin
      busy      <= 1'b1;
      step_q    <= '0;
      last_step <= steps_m1[grn_pkg::step_width-1:0];
    end else if (push && push_last) begin
      busy <= 1'b0;
    end else if (push) begin
      step_q <= step_q + 1'b1;
    end
  end

  // Gene state advances only when its record has been taken
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      state_q <= seed;
    end else if (push && !push_last) begin
      state_q <= state_next;
    end
  end

  // Back-pressure must not lose or alter the pending record
  assert property (@(posedge clk) disable iff (!rst_n) busy && full |=> $stable(push_record))
    else $error("push_record changed while the FIFO was full");

endmodule

// ==== hw/grn_csr.sv ====
/*
 * AXI4-Lite register front end of the GRN unit.
 * Holds the seed and step count, issues the start pulse and reports status.
 * Reads in the 0x100 window are served from the result memory through a
 * registered read port, so they take one extra wait cycle.
 */
`timescale 1ns/100ps

module grn_csr (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [grn_pkg::addr_width-1:0]       awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [grn_pkg::data_width-1:0]       wdata,
  input  logic [grn_pkg::data_width/8-1:0]     wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  input  logic [grn_pkg::addr_width-1:0]       araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [grn_pkg::data_width-1:0]       rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic                                 start,
  output logic [grn_pkg::gene_count-1:0]       seed,
  output logic [grn_pkg::step_width:0]         steps,
  input  logic                                 busy,
  input  logic                                 done,
  input  logic [grn_pkg::step_width:0]         count,
  output logic [grn_pkg::step_width-1:0]       mem_rd_addr,
  input  logic [grn_pkg::data_width-1:0]       mem_rd_data
);

  logic                            aw_hs;
  logic                            ar_hs;
  logic [grn_pkg::data_width-1:0]  wr_old;
  logic [grn_pkg::data_width-1:0]  wr_word;
  logic                            steps_legal;
  logic                            run_pending;
  logic [1:0]                      rd_state;
  logic                            rd_is_mem;

  // AW and W are taken together, and only while no response is waiting
  assign aw_hs   = awvalid && wvalid && !bvalid;
  assign awready = aw_hs;
  assign wready  = aw_hs;

  // Merge the written bytes over the current register value
  always_comb begin
    case (awaddr)
      grn_pkg::reg_seed:  wr_old = {{(grn_pkg::data_width-grn_pkg::gene_count){1'b0}}, seed};
      grn_pkg::reg_steps: wr_old = {{(grn_pkg::data_width-grn_pkg::step_width-1){1'b0}}, steps};
      default:            wr_old = '0;
    endcase
    for (int b = 0; b < grn_pkg::data_width/8; b++) begin
      wr_word[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : wr_old[8*b +: 8];
    end
  end

  // A step count outside 1 to max_steps is refused
  assign steps_legal = (wr_word != '0) &&
                       (wr_word <= grn_pkg::data_width'(grn_pkg::max_steps));

  // Write FSM, bvalid itself marks the response state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid      <= 1'b0;
      bresp       <= grn_pkg::resp_okay;
      start       <= 1'b0;
      run_pending <= 1'b0;
      seed        <= '0;
      steps       <= (grn_pkg::step_width+1)'(1);
    end else begin
      start <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      // The run stays pending until the requestor reports done
      // The old done is still high while the new start pulse is out
      if (done && !start) begin
        run_pending <= 1'b0;
      end
      if (aw_hs) begin
        bvalid <= 1'b1;
        bresp  <= grn_pkg::resp_okay;
        case (awaddr)
          grn_pkg::reg_ctrl: begin
            // A start during a run is accepted on the bus but dropped
            if (wr_word[0] && !busy && !run_pending) begin
              start       <= 1'b1;
              run_pending <= 1'b1;
            end
          end
          grn_pkg::reg_seed: begin
            seed <= wr_word[grn_pkg::gene_count-1:0];
          end
          grn_pkg::reg_steps: begin
            if (steps_legal) begin
              steps <= wr_word[grn_pkg::step_width:0];
            end else begin
              bresp <= grn_pkg::resp_slverr;
            end
          end
          // Status, memory and unmapped offsets are not writable
          default: bresp <= grn_pkg::resp_slverr;
        endcase
      end
    end
  end

  assign ar_hs     = arvalid && (rd_state == grn_pkg::rd_idle);
  assign arready   = ar_hs;
  assign rd_is_mem = araddr[grn_pkg::addr_width-1:8] == grn_pkg::mem_base[grn_pkg::addr_width-1:8];

  // The requestor registers this address, data comes back in rd_wait
  assign mem_rd_addr = araddr[grn_pkg::step_width+1:2];

  // Read FSM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_state <= grn_pkg::rd_idle;
      rvalid   <= 1'b0;
    end else begin
      case (rd_state)
        grn_pkg::rd_idle: begin
          if (ar_hs && rd_is_mem) begin
            rd_state <= grn_pkg::rd_wait;
          end else if (ar_hs) begin
            rvalid   <= 1'b1;
            rd_state <= grn_pkg::rd_resp;
          end
        end
        grn_pkg::rd_wait: begin
          rvalid   <= 1'b1;
          rd_state <= grn_pkg::rd_resp;
        end
        grn_pkg::rd_resp: begin
          if (rready) begin
            rvalid   <= 1'b0;
            rd_state <= grn_pkg::rd_idle;
          end
        end
        default: rd_state <= grn_pkg::rd_idle;
      endcase
    end
  end

  // Read data and response, held until the next read
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rresp <= grn_pkg::resp_okay;
      rdata <= '0;
      case (araddr)
        grn_pkg::reg_ctrl:  rdata <= '0;
        grn_pkg::reg_seed:  rdata <= {{(grn_pkg::data_width-grn_pkg::gene_count){1'b0}}, seed};
        grn_pkg::reg_steps: rdata <= {{(grn_pkg::data_width-grn_pkg::step_width-1){1'b0}}, steps};
        // Busy in bit 0, done in bit 1, count in bits 14:8
        grn_pkg::reg_status: rdata <= {{(grn_pkg::data_width-15){1'b0}}, count, 6'b0, done, busy};
        default: begin
          if (!rd_is_mem) begin
            rresp <= grn_pkg::resp_slverr;
          end
        end
      endcase
    end else if (rd_state == grn_pkg::rd_wait) begin
      rdata <= mem_rd_data;
    end
  end

  // Each write response must trace back to an AW and W handshake
  assert property (@(posedge clk) disable iff (!rst_n) $rose(bvalid) |-> $past(aw_hs))
    else $error("bvalid rose without a write handshake");

endmodule

// ==== hw/grn_pkg.sv ====
/*
 * Shared definitions for the GRN accelerator function unit.
 * Holds the sizes, the AXI4-Lite register map, the response codes, the
 * read FSM encoding and the transient record layout. Every design file
 * refers to these by scoped name.
 */
package grn_pkg;

  // Network size and run limits
  localparam int gene_count = 16;
  localparam int max_steps  = 64;
  localparam int step_width = 6;

  // AXI4-Lite bus sizes
  localparam int addr_width = 12;
  localparam int data_width = 32;

  // Record FIFO between the network and the requestor
  localparam int fifo_depth     = 8;
  localparam int fifo_ptr_width = $clog2(fifo_depth);

  // Register offsets; the memory window spans 0x100 to 0x1FC
  localparam logic [addr_width-1:0] reg_ctrl   = 12'h000;
  localparam logic [addr_width-1:0] reg_seed   = 12'h004;
  localparam logic [addr_width-1:0] reg_steps  = 12'h008;
  localparam logic [addr_width-1:0] reg_status = 12'h00C;
  localparam logic [addr_width-1:0] mem_base   = 12'h100;

  // AXI response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Read FSM states, memory reads pass through rd_wait
  localparam logic [1:0] rd_idle = 2'd0;
  localparam logic [1:0] rd_wait = 2'd1;
  localparam logic [1:0] rd_resp = 2'd2;

  // One transient record per network step
  // The network fills the fields view and the result memory keeps the raw word
  typedef union packed {
    logic [data_width-1:0] raw;
    struct packed {
      logic [9:0]            spare;
      logic [step_width-1:0] step;
      logic [gene_count-1:0] state;
    } fields;
  } transient_t;

endpackage
